/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the exu testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module exu_tb -f list.f -Mdir obj_dir -o exu_tb_sim
	@out="$$(./obj_dir/exu_tb_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

/* list.f */
+incdir+verification
verilog/xlen_pkg.sv
verilog/exu_op_pkg.sv
verilog/exu_adder.sv
verilog/exu_branch_unit.sv
verilog/exu_alu.sv
verilog/exu_multiplier.sv
verilog/exu_divider.sv
verilog/exu.sv
verification/exu_tb.sv

/* verification/exu_ref_model.svh */
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

// expected result word from src1 and the selected second operand b
function automatic word_t compute_result(input alu_op_e op, input word_t a, input word_t b);
	dword_t uu;
	dword_t ss;
	dword_t su;
	int     sa;
	int     sb;
	logic   ovf;
	word_t  res;
	sa  = a;
	sb  = b;
	ovf = (a == 32'h8000_0000) && (b == '1);
	// full 64-bit products of the extended operands
	uu  = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
	ss  = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
	su  = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
	res = '0;
	case (op)
		ADD:    res = a + b;
		SUB:    res = a - b;
		SLT:    res = word_t'($signed(a) < $signed(b));
		SLTU:   res = word_t'(a < b);
		AND:    res = a & b;
		OR:     res = a | b;
		XOR:    res = a ^ b;
		SLL:    res = a << b[4:0];
		SRL:    res = a >> b[4:0];
		SRA:    res = word_t'($signed(a) >>> b[4:0]);
		PASS_B: res = b;
		MUL:    res = uu[XLEN-1:0];
		MULH:   res = ss[2*XLEN-1:XLEN];
		MULHSU: res = su[2*XLEN-1:XLEN];
		MULHU:  res = uu[2*XLEN-1:XLEN];
		DIV: begin
			if (b == '0) res = '1;
			else if (ovf) res = 32'h8000_0000;
			else res = word_t'(sa / sb);
		end
		DIVU: res = (b == '0) ? '1 : a / b;
		REM: begin
			if (b == '0) res = a;
			else if (ovf) res = '0;
			else res = word_t'(sa % sb);
		end
		REMU: res = (b == '0) ? a : a % b;
		// branches write nothing
		default: res = '0;
	endcase
	return res;
endfunction

function automatic logic branch_condition(input alu_op_e op, input word_t a, input word_t b);
	case (op)
		BEQ:     return a == b;
		BNE:     return a != b;
		BLT:     return $signed(a) < $signed(b);
		BGE:     return $signed(a) >= $signed(b);
		BLTU:    return a < b;
		BGEU:    return a >= b;
		default: return 1'b0;
	endcase
endfunction

function automatic word_t pc_target(input word_t pc, input word_t imm, input logic target_imm);
	return target_imm ? pc + imm : pc + 32'd4;
endfunction

`endif

/* verification/exu_tb.sv */
`timescale 1ns/10ps

module exu_tb;
	import xlen_pkg::*;
	import exu_op_pkg::*;

	`include "exu_ref_model.svh"

	localparam int OP_TIMEOUT = 100;

	logic       clock;
	logic       reset;
	logic       start;
	logic       retire;
	exu_issue_t issue;
	word_t      result;
	logic       finished;
	logic       branch_taken;
	word_t      addr_sum;
	word_t      next_pc;

	integer seed = 32'hc25b;
	int     errors = 0;
	int     checks = 0;
	bit     timed_out = 1'b0;

	alu_op_e alu_ops[11] = '{ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA, PASS_B};
	alu_op_e branch_ops[6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
	alu_op_e mul_ops[4] = '{MUL, MULH, MULHSU, MULHU};
	alu_op_e div_ops[4] = '{DIV, DIVU, REM, REMU};

	exu i_exu (
		.clock        (clock),
		.reset        (reset),
		.start        (start),
		.retire       (retire),
		.issue        (issue),
		.result       (result),
		.finished     (finished),
		.branch_taken (branch_taken),
		.addr_sum     (addr_sum),
		.next_pc      (next_pc)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	// extremes now and then
	function automatic word_t random_operand();
		case ({$random(seed)} % 8)
			0: return '0;
			1: return 32'h8000_0000;
			2: return '1;
			3: return 32'd1;
			default: return $random(seed);
		endcase
	endfunction

	function automatic exu_issue_t random_issue(input alu_op_e op);
		exu_issue_t item;
		item.op         = op;
		item.pc         = $random(seed) & 32'hffff_fffc;
		item.src1       = random_operand();
		item.src2       = random_operand();
		item.imm        = $random(seed);
		item.use_src2   = 1'($random(seed));
		item.target_imm = 1'($random(seed));
		return item;
	endfunction

	// one instruction from start to retire
	task automatic run_op(input exu_issue_t item, input bit single_cycle);
		int    cycles;
		int    hold;
		word_t b;
		word_t held;
		b      = item.use_src2 ? item.src2 : item.imm;
		issue  = item;
		start  = 1'b1;
		@(posedge clock);
		#1;
		start  = 1'b0;
		cycles = 1;
		while (!finished && cycles < OP_TIMEOUT) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (!finished) begin
			$display("timeout: %s did not finish within %0d cycles", item.op.name(), OP_TIMEOUT);
			errors++;
			timed_out = 1'b1;
		end else begin
			if (single_cycle)
				check_value("finished latency", word_t'(cycles), 32'd2);
			check_value("result", result, compute_result(item.op, item.src1, b));
			check_value("branch_taken", word_t'(branch_taken),
				word_t'(branch_condition(item.op, item.src1, b)));
			check_value("next_pc", next_pc, pc_target(item.pc, item.imm, item.target_imm));
			if (item.op == ADD && !item.use_src2)
				check_value("addr_sum", addr_sum, item.src1 + item.imm);
			// write-back holds off for a while
			held = result;
			hold = {$random(seed)} % 5;
			repeat (hold) begin
				@(posedge clock);
				#1;
				check_value("result", result, held);
				check_value("finished", word_t'(finished), 32'd1);
			end
			retire = 1'b1;
			@(posedge clock);
			#1;
			retire = 1'b0;
			check_value("finished", word_t'(finished), 32'd0);
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	task automatic run_all();
		exu_issue_t item;
		int         i;
		int         pick;
		for (i = 0; i < 40; i++) begin
			pick = {$random(seed)} % 11;
			item = random_issue(alu_ops[pick]);
			run_op(item, 1'b1);
			if (timed_out) return;
		end
		// branches with equal operands every third time or so
		for (i = 0; i < 30; i++) begin
			pick = {$random(seed)} % 6;
			item = random_issue(branch_ops[pick]);
			item.use_src2 = 1'b1;
			if ({$random(seed)} % 3 == 0)
				item.src2 = item.src1;
			run_op(item, 1'b1);
			if (timed_out) return;
		end
		// load and store address
		for (i = 0; i < 8; i++) begin
			item = random_issue(ADD);
			item.use_src2 = 1'b0;
			run_op(item, 1'b1);
			if (timed_out) return;
		end
		for (pick = 0; pick < 4; pick++) begin
			for (i = 0; i < 6; i++) begin
				item = random_issue(mul_ops[pick]);
				item.use_src2 = 1'b1;
				run_op(item, 1'b0);
				if (timed_out) return;
			end
		end
		// divide by zero first, then signed overflow
		for (pick = 0; pick < 4; pick++) begin
			for (i = 0; i < 8; i++) begin
				item = random_issue(div_ops[pick]);
				item.use_src2 = 1'b1;
				if (i == 0) begin
					item.src2 = '0;
				end else if (i == 1) begin
					item.src1 = 32'h8000_0000;
					item.src2 = '1;
				end
				run_op(item, 1'b0);
				if (timed_out) return;
			end
		end
	endtask

	initial begin
		start  = 1'b0;
		retire = 1'b0;
		issue  = '0;
		reset  = 1'b1;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		run_all();
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* verilog/exu.sv */
`timescale 1ns/10ps

module exu (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   start,
	input  logic                   retire,
	input  exu_op_pkg::exu_issue_t issue,
	output xlen_pkg::word_t        result,
	output logic                   finished,
	output logic                   branch_taken,
	output xlen_pkg::word_t        addr_sum,
	output xlen_pkg::word_t        next_pc
);
	import xlen_pkg::*;
	import exu_op_pkg::*;

	word_t        op_a;
	word_t        op_b;
	word_t        pc_b;
	logic         subtract;
	adder_flags_t flags;
	word_t        alu_result;
	logic         is_mul;
	logic         is_div;
	logic         pending;
	logic         mdu_busy;
	logic         mul_go;
	logic         div_go;
	logic         mul_done;
	logic         div_done;
	dword_t       product;
	word_t        quotient;
	word_t        remainder;

	// ----------------------------------------
	// operands and single-cycle path
	// ----------------------------------------
	assign op_a     = issue.src1;
	assign op_b     = issue.use_src2 ? issue.src2 : issue.imm;
	assign pc_b     = issue.target_imm ? issue.imm : word_t'(4);
	assign subtract = issue.op inside {SUB, SLT, SLTU, BEQ, BNE, BLT, BGE, BLTU, BGEU};
	assign is_mul   = issue.op inside {MUL, MULH, MULHSU, MULHU};
	assign is_div   = issue.op inside {DIV, DIVU, REM, REMU};

	exu_adder i_op_adder (
		.a        (op_a),
		.b        (op_b),
		.subtract (subtract),
		.sum      (addr_sum),
		.flags    (flags)
	);

	// flags of the pc sum are not needed
	exu_adder i_pc_adder (
		.a        (issue.pc),
		.b        (pc_b),
		.subtract (1'b0),
		.sum      (next_pc),
		.flags    ()
	);

	exu_branch_unit i_branch_unit (
		.op    (issue.op),
		.flags (flags),
		.taken (branch_taken)
	);

	exu_alu i_alu (
		.op     (issue.op),
		.a      (op_a),
		.b      (op_b),
		.sum    (addr_sum),
		.flags  (flags),
		.result (alu_result)
	);

	// ----------------------------------------
	// multiply and divide
	// ----------------------------------------
	// go in the cycle after start
	assign mul_go = pending & is_mul;
	assign div_go = pending & is_div;

	exu_multiplier i_multiplier (
		.clock        (clock),
		.reset        (reset),
		.go           (mul_go),
		.a_signed     (issue.op inside {MUL, MULH, MULHSU}),
		.b_signed     (issue.op inside {MUL, MULH}),
		.multiplicand (op_a),
		.multiplier   (op_b),
		.done         (mul_done),
		.product      (product)
	);

	exu_divider i_divider (
		.clock     (clock),
		.reset     (reset),
		.go        (div_go),
		.is_signed (issue.op inside {DIV, REM}),
		.dividend  (op_a),
		.divisor   (op_b),
		.done      (div_done),
		.quotient  (quotient),
		.remainder (remainder)
	);

	// ----------------------------------------
	// sequencing and result register
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			pending  <= 1'b0;
			mdu_busy <= 1'b0;
			finished <= 1'b0;
			result   <= '0;
		end else begin
			pending <= start;
			if (mul_go || div_go) begin
				mdu_busy <= 1'b1;
			end else if (mul_done || div_done) begin
				mdu_busy <= 1'b0;
			end
			if (mul_done) begin
				result   <= (issue.op == MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
				finished <= 1'b1;
			end else if (div_done) begin
				result   <= issue.op inside {DIV, DIVU} ? quotient : remainder;
				finished <= 1'b1;
			end else if (pending && !is_mul && !is_div) begin
				result   <= alu_result;
				finished <= 1'b1;
			end else if (retire) begin
				finished <= 1'b0;
			end
		end
	end

	// one item in flight
	a_start_idle: assert property (@(posedge clock) disable iff (reset)
		start |-> !finished && !pending && !mdu_busy);

	a_retire_finished: assert property (@(posedge clock) disable iff (reset)
		retire |-> finished);

endmodule

/* verilog/exu_adder.sv */
`timescale 1ns/10ps

module exu_adder (
	input  xlen_pkg::word_t          a,
	input  xlen_pkg::word_t          b,
	input  logic                     subtract,
	output xlen_pkg::word_t          sum,
	output exu_op_pkg::adder_flags_t flags
);
	import xlen_pkg::*;

	word_t       b_eff;
	logic [XLEN:0] full;

	// a - b as a + ~b + 1
	assign b_eff = subtract ? ~b : b;
	assign full  = {1'b0, a} + {1'b0, b_eff} + {{XLEN{1'b0}}, subtract};
	assign sum   = full[XLEN-1:0];

	// no carry out of a subtract means a borrow
	assign flags.zero        = (sum == '0);
	assign flags.lt_unsigned = ~full[XLEN];
	// with different signs the negative one is smaller
	assign flags.lt_signed   = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : sum[XLEN-1];

endmodule

/* verilog/exu_alu.sv */
`timescale 1ns/10ps

module exu_alu (
	input  exu_op_pkg::alu_op_e      op,
	input  xlen_pkg::word_t          a,
	input  xlen_pkg::word_t          b,
	input  xlen_pkg::word_t          sum,
	input  exu_op_pkg::adder_flags_t flags,
	output xlen_pkg::word_t          result
);
	import xlen_pkg::*;
	import exu_op_pkg::*;

	logic [4:0] shamt;

	// only the low five bits count for a 32-bit shift
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			ADD, SUB: begin
				result = sum;
			end
			SLT: begin
				result = {{(XLEN-1){1'b0}}, flags.lt_signed};
			end
			SLTU: begin
				result = {{(XLEN-1){1'b0}}, flags.lt_unsigned};
			end
			AND: begin
				result = a & b;
			end
			OR: begin
				result = a | b;
			end
			XOR: begin
				result = a ^ b;
			end
			SLL: begin
				result = a << shamt;
			end
			SRL: begin
				result = a >> shamt;
			end
			SRA: begin
				result = word_t'($signed(a) >>> shamt);
			end
			// lui
			PASS_B: begin
				result = b;
			end
			// branches, multiply and divide
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

/* verilog/exu_branch_unit.sv */
`timescale 1ns/10ps

module exu_branch_unit (
	input  exu_op_pkg::alu_op_e      op,
	input  exu_op_pkg::adder_flags_t flags,
	output logic                     taken
);
	import exu_op_pkg::*;

	// condition per branch op from the flags of src1 - src2
	always_comb begin
		case (op)
			BEQ: begin
				taken = flags.zero;
			end
			BNE: begin
				taken = ~flags.zero;
			end
			BLT: begin
				taken = flags.lt_signed;
			end
			BGE: begin
				taken = ~flags.lt_signed;
			end
			BLTU: begin
				taken = flags.lt_unsigned;
			end
			BGEU: begin
				taken = ~flags.lt_unsigned;
			end
			default: begin
				taken = 1'b0;
			end
		endcase
	end

endmodule

/* verilog/exu_divider.sv */
`timescale 1ns/10ps

module exu_divider (
	input  logic            clock,
	input  logic            reset,
	input  logic            go,
	input  logic            is_signed,
	input  xlen_pkg::word_t dividend,
	input  xlen_pkg::word_t divisor,
	output logic            done,
	output xlen_pkg::word_t quotient,
	output xlen_pkg::word_t remainder
);
	import xlen_pkg::*;
	import exu_op_pkg::*;

	mdu_state_e             state;
	logic [MDU_COUNT_W-1:0] count;
	logic                   q_neg;
	logic                   r_neg;
	word_t                  q_r;
	word_t                  r_r;
	word_t                  dvs_r;
	logic                   dvd_neg;
	logic                   dvs_neg;
	logic                   div_zero;
	logic                   overflow;
	logic [XLEN:0]          shifted;
	logic [XLEN:0]          diff;
	logic                   fits;
	word_t                  q_next;
	word_t                  r_next;

	assign dvd_neg  = is_signed & dividend[XLEN-1];
	assign dvs_neg  = is_signed & divisor[XLEN-1];
	assign div_zero = (divisor == '0);
	// most negative value divided by -1
	assign overflow = is_signed && (dividend == {1'b1, {(XLEN-1){1'b0}}}) && (divisor == '1);

	// ----------------------------------------
	// one restoring step
	// ----------------------------------------
	assign shifted = {r_r, q_r[XLEN-1]};
	assign diff    = shifted - {1'b0, dvs_r};
	assign fits    = (shifted >= {1'b0, dvs_r});
	assign r_next  = fits ? diff[XLEN-1:0] : shifted[XLEN-1:0];
	assign q_next  = {q_r[XLEN-2:0], fits};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			count <= '0;
		end else begin
			case (state)
				BUSY: begin
					q_r   <= q_next;
					r_r   <= r_next;
					count <= count + MDU_COUNT_W'(1);
					if (count == MDU_COUNT_W'(MDU_ITERATIONS - 1)) begin
						// quotient sign from both operands and remainder sign from the dividend
						quotient  <= q_neg ? -q_next : q_next;
						remainder <= r_neg ? -r_next : r_next;
						state     <= DONE;
					end
				end
				default: begin
					state <= IDLE;
					if (go && div_zero) begin
						quotient  <= '1;
						remainder <= dividend;
						state     <= DONE;
					end else if (go && overflow) begin
						quotient  <= {1'b1, {(XLEN-1){1'b0}}};
						remainder <= '0;
						state     <= DONE;
					end else if (go) begin
						q_r   <= dvd_neg ? -dividend : dividend;
						r_r   <= '0;
						dvs_r <= dvs_neg ? -divisor : divisor;
						q_neg <= dvd_neg ^ dvs_neg;
						r_neg <= dvd_neg;
						count <= '0;
						state <= BUSY;
					end
				end
			endcase
		end
	end

	assign done = (state == DONE);

	a_go_idle: assert property (@(posedge clock) disable iff (reset) go |-> state != BUSY);

endmodule

/* verilog/exu_multiplier.sv */
`timescale 1ns/10ps

module exu_multiplier (
	input  logic             clock,
	input  logic             reset,
	input  logic             go,
	input  logic             a_signed,
	input  logic             b_signed,
	input  xlen_pkg::word_t  multiplicand,
	input  xlen_pkg::word_t  multiplier,
	output logic             done,
	output xlen_pkg::dword_t product
);
	import xlen_pkg::*;
	import exu_op_pkg::*;

	mdu_state_e             state;
	logic [MDU_COUNT_W-1:0] count;
	logic                   negate;
	dword_t                 acc;
	dword_t                 acc_next;
	dword_t                 mcand;
	word_t                  mplier;
	logic                   a_neg;
	logic                   b_neg;
	word_t                  a_mag;
	word_t                  b_mag;

	// operand magnitudes
	assign a_neg = a_signed & multiplicand[XLEN-1];
	assign b_neg = b_signed & multiplier[XLEN-1];
	assign a_mag = a_neg ? -multiplicand : multiplicand;
	assign b_mag = b_neg ? -multiplier : multiplier;

	// add the shifted multiplicand for each set bit
	assign acc_next = mplier[0] ? acc + mcand : acc;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			count <= '0;
		end else begin
			case (state)
				BUSY: begin
					acc    <= acc_next;
					mcand  <= mcand << 1;
					mplier <= mplier >> 1;
					count  <= count + MDU_COUNT_W'(1);
					if (count == MDU_COUNT_W'(MDU_ITERATIONS - 1)) begin
						product <= negate ? -acc_next : acc_next;
						state   <= DONE;
					end
				end
				default: begin
					state <= IDLE;
					if (go) begin
						acc    <= '0;
						mcand  <= {{XLEN{1'b0}}, a_mag};
						mplier <= b_mag;
						negate <= a_neg ^ b_neg;
						count  <= '0;
						state  <= BUSY;
					end
				end
			endcase
		end
	end

	assign done = (state == DONE);

	// the top level issues one go per operation
	a_go_idle: assert property (@(posedge clock) disable iff (reset) go |-> state != BUSY);

endmodule

/* verilog/exu_op_pkg.sv */
package exu_op_pkg;

	// ----------------------------------------
	// operation codes
	// ----------------------------------------
	typedef enum logic [4:0] {
		ADD, SUB, SLT, SLTU,
		AND, OR, XOR,
		SLL, SRL, SRA,
		PASS_B,
		BEQ, BNE, BLT, BGE, BLTU, BGEU,
		MUL, MULH, MULHSU, MULHU,
		DIV, DIVU, REM, REMU
	} alu_op_e;

	// one decoded instruction
	typedef struct packed {
		alu_op_e       op;
		xlen_pkg::word_t pc;
		xlen_pkg::word_t src1;
		xlen_pkg::word_t src2;
		xlen_pkg::word_t imm;
		logic          use_src2;
		logic          target_imm;
	} exu_issue_t;

	// compare results of a - b
	typedef struct packed {
		logic zero;
		logic lt_signed;
		logic lt_unsigned;
	} adder_flags_t;

	// shared by multiplier and divider
	typedef enum logic [1:0] {IDLE, BUSY, DONE} mdu_state_e;

endpackage

/* verilog/xlen_pkg.sv */
package xlen_pkg;

	// ----------------------------------------
	// data width
	// ----------------------------------------
	localparam int XLEN = 32;

	// one register word
	typedef logic [XLEN-1:0] word_t;

	// full product of two words
	typedef logic [2*XLEN-1:0] dword_t;

	// ----------------------------------------
	// iterative multiply and divide
	// ----------------------------------------
	// one step per operand bit
	localparam int MDU_ITERATIONS = 32;

	// wide enough to hold MDU_ITERATIONS
	localparam int MDU_COUNT_W = 6;

endpackage
